//--- verilog/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Image held in the on-chip buffer
`define CONV_IMG_ROWS 8
`define CONV_IMG_COLS 8

// Kernel size, also the PE array size
`define CONV_K 3

// Datapath widths
`define CONV_PIX_W  8
`define CONV_PSUM_W 18
`define CONV_SUM_W  20

// Window issue to result strobe
`define CONV_LATENCY 6

// Valid convolution, no padding
`define CONV_OUT_ROWS (`CONV_IMG_ROWS - `CONV_K + 1)
`define CONV_OUT_COLS (`CONV_IMG_COLS - `CONV_K + 1)
`define CONV_GROUPS   (`CONV_OUT_ROWS / `CONV_K)

`endif

//--- verilog/conv_geom_pkg.sv
`include "conv_params.svh"

package conv_geom_pkg;

  // One pixel or filter tap
  typedef logic [`CONV_PIX_W-1:0] pixel_t;

  // Left pixel in the high byte
  typedef pixel_t [0:`CONV_K-1] window_t;

  // Filter row 0 in the high bits
  typedef window_t [0:`CONV_K-1] filter_t;

  // Three-tap dot product of one PE
  typedef logic [`CONV_PSUM_W-1:0] psum_t;

  // Full 3x3 sum, wide enough for all-ones operands
  typedef logic [`CONV_SUM_W-1:0] osum_t;

endpackage

//--- verilog/conv_ctrl_pkg.sv
`include "conv_params.svh"

package conv_ctrl_pkg;

  typedef enum logic {
    IDLE,
    RUN
  } seq_state_t;

  typedef logic [$clog2(`CONV_IMG_ROWS)-1:0] row_idx_t;
  typedef logic [$clog2(`CONV_IMG_COLS)-1:0] col_idx_t;

  // Keep one bit even with a single group
  typedef logic [(`CONV_GROUPS > 1 ? $clog2(`CONV_GROUPS) : 1)-1:0] grp_idx_t;

endpackage

//--- verilog/image_row_buffer.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module image_row_buffer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_we,
  input  conv_ctrl_pkg::row_idx_t  i_wr_row,
  input  conv_ctrl_pkg::col_idx_t  i_wr_col,
  input  conv_geom_pkg::pixel_t    i_wr_data,
  input  logic                     i_busy,
  input  logic                     i_rd,
  input  conv_ctrl_pkg::row_idx_t  i_rd_row_base,
  input  conv_ctrl_pkg::col_idx_t  i_rd_col,
  output conv_geom_pkg::window_t   o_win0,
  output conv_geom_pkg::window_t   o_win1,
  output conv_geom_pkg::window_t   o_win2,
  output conv_geom_pkg::window_t   o_win3,
  output conv_geom_pkg::window_t   o_win4
);

  // Column 0 sits in the high byte of each row
  conv_geom_pkg::pixel_t [0:`CONV_IMG_COLS-1] img_row [`CONV_IMG_ROWS];

  function automatic conv_geom_pkg::window_t window_at(
    input int                      row_ofs,
    input conv_ctrl_pkg::col_idx_t col
  );
    conv_ctrl_pkg::row_idx_t row;
    row = conv_ctrl_pkg::row_idx_t'(int'(i_rd_row_base) + row_ofs);
    return img_row[row][col +: `CONV_K];
  endfunction

  // Host writes are locked out during a run
  always_ff @(posedge clk)
  begin
    if (i_we && !i_busy)
    begin
      img_row[i_wr_row][i_wr_col] <= i_wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      o_win0 <= '0;
      o_win1 <= '0;
      o_win2 <= '0;
      o_win3 <= '0;
      o_win4 <= '0;
    end
    else if (i_rd)
    begin
      o_win0 <= window_at(0, i_rd_col);
      o_win1 <= window_at(1, i_rd_col);
      o_win2 <= window_at(2, i_rd_col);
      o_win3 <= window_at(3, i_rd_col);
      o_win4 <= window_at(4, i_rd_col);
    end
  end

  // Sequencer must keep all five rows and three columns inside the image
  a_rd_in_image: assert property (@(posedge clk) disable iff (!rst_n)
    i_rd |-> (int'(i_rd_row_base) + 2 * `CONV_K - 2 < `CONV_IMG_ROWS) &&
             (int'(i_rd_col) + `CONV_K - 1 < `CONV_IMG_COLS))
    else $error("window read outside image, row %0d col %0d", i_rd_row_base, i_rd_col);

endmodule

//--- verilog/window_sequencer.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module window_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_start,
  input  conv_geom_pkg::filter_t   i_filter,
  input  conv_geom_pkg::window_t   i_win3,
  input  conv_geom_pkg::window_t   i_win4,
  output logic                     o_busy,
  output logic                     o_rd,
  output conv_ctrl_pkg::row_idx_t  o_rd_row_base,
  output conv_ctrl_pkg::col_idx_t  o_rd_col,
  output conv_geom_pkg::window_t   o_win3_d,
  output conv_geom_pkg::window_t   o_win4_d,
  output conv_geom_pkg::window_t   o_frow0,
  output conv_geom_pkg::window_t   o_frow1,
  output conv_geom_pkg::window_t   o_frow2,
  output logic                     o_valid,
  output conv_ctrl_pkg::grp_idx_t  o_grp,
  output conv_ctrl_pkg::col_idx_t  o_col,
  output logic                     o_done
);

  localparam conv_ctrl_pkg::grp_idx_t LAST_GRP = conv_ctrl_pkg::grp_idx_t'(`CONV_GROUPS - 1);
  localparam conv_ctrl_pkg::col_idx_t LAST_COL = conv_ctrl_pkg::col_idx_t'(`CONV_OUT_COLS - 1);

  conv_ctrl_pkg::seq_state_t state;
  conv_ctrl_pkg::grp_idx_t   grp_cnt;
  conv_ctrl_pkg::col_idx_t   col_cnt;
  logic                      start_ok;
  logic                      last_cnt;
  logic                      iss_vld;
  conv_ctrl_pkg::grp_idx_t   iss_grp;
  conv_ctrl_pkg::col_idx_t   iss_col;
  conv_geom_pkg::window_t    win4_d1;
  logic [`CONV_LATENCY-1:0]  vld_pipe;
  conv_ctrl_pkg::grp_idx_t   grp_pipe [`CONV_LATENCY];
  conv_ctrl_pkg::col_idx_t   col_pipe [`CONV_LATENCY];

  assign start_ok = i_start && !o_busy;
  assign last_cnt = (grp_cnt == LAST_GRP) && (col_cnt == LAST_COL);

  //////////////////////////////
  // Run control and issue order
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= conv_ctrl_pkg::IDLE;
      grp_cnt <= '0;
      col_cnt <= '0;
      o_busy  <= 1'b0;
      iss_vld <= 1'b0;
      iss_grp <= '0;
      iss_col <= '0;
    end
    else
    begin
      iss_vld <= (state == conv_ctrl_pkg::RUN);
      iss_grp <= grp_cnt;
      iss_col <= col_cnt;
      // Busy covers the drain of the pipeline
      if (start_ok)
        o_busy <= 1'b1;
      else if (o_done)
        o_busy <= 1'b0;
      case (state)
        conv_ctrl_pkg::IDLE:
        begin
          if (start_ok)
          begin
            state   <= conv_ctrl_pkg::RUN;
            grp_cnt <= '0;
            col_cnt <= '0;
          end
        end
        default:
        begin
          // Group-major, then column-major
          if (col_cnt == LAST_COL)
          begin
            col_cnt <= '0;
            grp_cnt <= grp_cnt + 1'b1;
          end
          else
          begin
            col_cnt <= col_cnt + 1'b1;
          end
          if (last_cnt)
            state <= conv_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Read request, skew and filter
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      o_rd          <= 1'b0;
      o_rd_row_base <= '0;
      o_rd_col      <= '0;
      o_win3_d      <= '0;
      win4_d1       <= '0;
      o_win4_d      <= '0;
      o_frow0       <= '0;
      o_frow1       <= '0;
      o_frow2       <= '0;
    end
    else
    begin
      o_rd          <= iss_vld;
      o_rd_row_base <= conv_ctrl_pkg::row_idx_t'(int'(iss_grp) * `CONV_K);
      o_rd_col      <= iss_col;
      // Rows 3 and 4 enter the array one and two hops late
      o_win3_d      <= i_win3;
      win4_d1       <= i_win4;
      o_win4_d      <= win4_d1;
      if (start_ok)
      begin
        o_frow0 <= i_filter[0];
        o_frow1 <= i_filter[1];
        o_frow2 <= i_filter[2];
      end
    end
  end

  // Strobe and tags ride alongside the datapath
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vld_pipe <= '0;
      for (int i = 0; i < `CONV_LATENCY; i++)
      begin
        grp_pipe[i] <= '0;
        col_pipe[i] <= '0;
      end
    end
    else
    begin
      vld_pipe    <= {vld_pipe[`CONV_LATENCY-2:0], iss_vld};
      grp_pipe[0] <= iss_grp;
      col_pipe[0] <= iss_col;
      for (int i = 1; i < `CONV_LATENCY; i++)
      begin
        grp_pipe[i] <= grp_pipe[i-1];
        col_pipe[i] <= col_pipe[i-1];
      end
    end
  end

  assign o_valid = vld_pipe[`CONV_LATENCY-1];
  assign o_grp   = grp_pipe[`CONV_LATENCY-1];
  assign o_col   = col_pipe[`CONV_LATENCY-1];
  assign o_done  = o_valid && (o_grp == LAST_GRP) && (o_col == LAST_COL);

  a_rd_only_busy: assert property (@(posedge clk) disable iff (!rst_n)
    o_rd |-> o_busy)
    else $error("buffer read issued while idle");

  // Last strobe closes the run on the next edge
  a_done_ends_run: assert property (@(posedge clk) disable iff (!rst_n)
    o_done |-> o_busy ##1 !o_busy)
    else $error("done pulse did not end the run");

endmodule

//--- verilog/conv_pe.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_pe (
  input  logic                    clk,
  input  logic                    rst_n,
  input  conv_geom_pkg::window_t  i_win,
  input  conv_geom_pkg::window_t  i_frow,
  output conv_geom_pkg::window_t  o_win_fwd,
  output conv_geom_pkg::psum_t    o_psum
);

  conv_geom_pkg::psum_t dot;

  // Unsigned three-tap dot product
  always_comb
  begin
    dot = '0;
    for (int j = 0; j < `CONV_K; j++)
    begin
      dot += conv_geom_pkg::psum_t'(i_win[j]) * conv_geom_pkg::psum_t'(i_frow[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      o_psum    <= '0;
      o_win_fwd <= '0;
    end
    else
    begin
      o_psum    <= dot;
      // Window moves on to the upper-right neighbor
      o_win_fwd <= i_win;
    end
  end

endmodule

//--- verilog/pe_array.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module pe_array (
  input  logic                    clk,
  input  logic                    rst_n,
  input  conv_geom_pkg::window_t  i_win0,
  input  conv_geom_pkg::window_t  i_win1,
  input  conv_geom_pkg::window_t  i_win2,
  input  conv_geom_pkg::window_t  i_win3_d,
  input  conv_geom_pkg::window_t  i_win4_d,
  input  conv_geom_pkg::window_t  i_frow0,
  input  conv_geom_pkg::window_t  i_frow1,
  input  conv_geom_pkg::window_t  i_frow2,
  output conv_geom_pkg::osum_t    o_sum0,
  output conv_geom_pkg::osum_t    o_sum1,
  output conv_geom_pkg::osum_t    o_sum2
);

  conv_geom_pkg::window_t entry   [2*`CONV_K-1];
  conv_geom_pkg::window_t frow    [`CONV_K];
  conv_geom_pkg::window_t pe_win  [`CONV_K][`CONV_K];
  conv_geom_pkg::window_t pe_fwd  [`CONV_K][`CONV_K];
  conv_geom_pkg::psum_t   pe_psum [`CONV_K][`CONV_K];
  conv_geom_pkg::psum_t   pe_al   [`CONV_K][`CONV_K];
  conv_geom_pkg::osum_t   col_sum [`CONV_K];

  assign entry[0] = i_win0;
  assign entry[1] = i_win1;
  assign entry[2] = i_win2;
  assign entry[3] = i_win3_d;
  assign entry[4] = i_win4_d;

  assign frow[0] = i_frow0;
  assign frow[1] = i_frow1;
  assign frow[2] = i_frow2;

  //////////////////////////////
  // PE mesh, PE(r,c) sees image row r+c
  //////////////////////////////

  for (genvar r = 0; r < `CONV_K; r++)
  begin : g_row
    for (genvar c = 0; c < `CONV_K; c++)
    begin : g_col
      if (c == 0)
      begin : g_left
        assign pe_win[r][c] = entry[r];
      end
      else if (r == `CONV_K - 1)
      begin : g_bottom
        assign pe_win[r][c] = entry[`CONV_K - 1 + c];
      end
      else
      begin : g_diag
        assign pe_win[r][c] = pe_fwd[r+1][c-1];
      end

      conv_pe u_pe (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_win     (pe_win[r][c]),
        .i_frow    (frow[r]),
        .o_win_fwd (pe_fwd[r][c]),
        .o_psum    (pe_psum[r][c])
      );

      // Hold early columns back until the last column catches up
      if (c == `CONV_K - 1)
      begin : g_nodly
        assign pe_al[r][c] = pe_psum[r][c];
      end
      else
      begin : g_dly
        conv_geom_pkg::psum_t dly_q [`CONV_K-1-c];

        always_ff @(posedge clk or negedge rst_n)
        begin
          if (!rst_n)
          begin
            for (int i = 0; i < `CONV_K-1-c; i++)
              dly_q[i] <= '0;
          end
          else
          begin
            dly_q[0] <= pe_psum[r][c];
            for (int i = 1; i < `CONV_K-1-c; i++)
              dly_q[i] <= dly_q[i-1];
          end
        end

        assign pe_al[r][c] = dly_q[`CONV_K-2-c];
      end
    end
  end

  //////////////////////////////
  // Column adders
  //////////////////////////////

  always_comb
  begin
    for (int c = 0; c < `CONV_K; c++)
    begin
      col_sum[c] = '0;
      for (int r = 0; r < `CONV_K; r++)
        col_sum[c] += conv_geom_pkg::osum_t'(pe_al[r][c]);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      o_sum0 <= '0;
      o_sum1 <= '0;
      o_sum2 <= '0;
    end
    else
    begin
      o_sum0 <= col_sum[0];
      o_sum1 <= col_sum[1];
      o_sum2 <= col_sum[2];
    end
  end

endmodule

//--- verilog/conv_row_stationary_top.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_row_stationary_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_pix_we,
  input  conv_ctrl_pkg::row_idx_t  i_pix_row,
  input  conv_ctrl_pkg::col_idx_t  i_pix_col,
  input  conv_geom_pkg::pixel_t    i_pix_data,
  input  logic                     i_start,
  input  conv_geom_pkg::filter_t   i_filter,
  output logic                     o_busy,
  output logic                     o_valid,
  output conv_ctrl_pkg::grp_idx_t  o_grp,
  output conv_ctrl_pkg::col_idx_t  o_col,
  output conv_geom_pkg::osum_t     o_sum0,
  output conv_geom_pkg::osum_t     o_sum1,
  output conv_geom_pkg::osum_t     o_sum2,
  output logic                     o_done
);

  logic                     rd;
  conv_ctrl_pkg::row_idx_t  rd_row_base;
  conv_ctrl_pkg::col_idx_t  rd_col;
  conv_geom_pkg::window_t   win0;
  conv_geom_pkg::window_t   win1;
  conv_geom_pkg::window_t   win2;
  conv_geom_pkg::window_t   win3;
  conv_geom_pkg::window_t   win4;
  conv_geom_pkg::window_t   win3_d;
  conv_geom_pkg::window_t   win4_d;
  conv_geom_pkg::window_t   frow0;
  conv_geom_pkg::window_t   frow1;
  conv_geom_pkg::window_t   frow2;

  image_row_buffer u_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_we          (i_pix_we),
    .i_wr_row      (i_pix_row),
    .i_wr_col      (i_pix_col),
    .i_wr_data     (i_pix_data),
    .i_busy        (o_busy),
    .i_rd          (rd),
    .i_rd_row_base (rd_row_base),
    .i_rd_col      (rd_col),
    .o_win0        (win0),
    .o_win1        (win1),
    .o_win2        (win2),
    .o_win3        (win3),
    .o_win4        (win4)
  );

  window_sequencer u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start),
    .i_filter      (i_filter),
    .i_win3        (win3),
    .i_win4        (win4),
    .o_busy        (o_busy),
    .o_rd          (rd),
    .o_rd_row_base (rd_row_base),
    .o_rd_col      (rd_col),
    .o_win3_d      (win3_d),
    .o_win4_d      (win4_d),
    .o_frow0       (frow0),
    .o_frow1       (frow1),
    .o_frow2       (frow2),
    .o_valid       (o_valid),
    .o_grp         (o_grp),
    .o_col         (o_col),
    .o_done        (o_done)
  );

  pe_array u_array (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_win0   (win0),
    .i_win1   (win1),
    .i_win2   (win2),
    .i_win3_d (win3_d),
    .i_win4_d (win4_d),
    .i_frow0  (frow0),
    .i_frow1  (frow1),
    .i_frow2  (frow2),
    .o_sum0   (o_sum0),
    .o_sum1   (o_sum1),
    .o_sum2   (o_sum2)
  );

endmodule

//--- verif/conv_checker.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module conv_checker (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     i_start,
  input logic                     o_busy,
  input logic                     o_valid,
  input conv_ctrl_pkg::grp_idx_t  o_grp,
  input conv_ctrl_pkg::col_idx_t  o_col,
  input conv_geom_pkg::osum_t     o_sum0,
  input conv_geom_pkg::osum_t     o_sum1,
  input conv_geom_pkg::osum_t     o_sum2,
  input logic                     o_done
);

  localparam int N_STROBES = `CONV_GROUPS * `CONV_OUT_COLS;

  conv_geom_pkg::osum_t exp_tab [`CONV_OUT_ROWS][`CONV_OUT_COLS];
  string test_name;
  int    test_errs;
  int    pass_tests;
  int    fail_tests;
  int    cyc;
  int    start_edge;
  int    n_strobes;
  int    n_done;
  logic  run_active;
  logic  fresh;
  logic  done_prev;

  initial
  begin
    test_name  = "none";
    test_errs  = 0;
    pass_tests = 0;
    fail_tests = 0;
    cyc        = 0;
    start_edge = 0;
    n_strobes  = 0;
    n_done     = 0;
    run_active = 1'b0;
    fresh      = 1'b1;
    done_prev  = 1'b0;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  task automatic flag_error(input string msg);
    $display("  error in %0s: %0s", test_name, msg);
    test_errs++;
  endtask

  task automatic compare_value(input string sig, input int row, input int col,
                               input logic [31:0] expv, input logic [31:0] got);
    if (expv !== got)
    begin
      $display("[FAIL] %0s row %0d col %0d: expected 0x%0h, got 0x%0h",
               sig, row, col, expv, got);
      test_errs++;
    end
  endtask

  task automatic set_expected(input int r, input int c, input conv_geom_pkg::osum_t v);
    exp_tab[r][c] = v;
  endtask

  // Reference rule straight from the 3x3 valid convolution
  task automatic compute_expected(input logic [`CONV_IMG_ROWS*`CONV_IMG_COLS*8-1:0] img,
                                  input conv_geom_pkg::filter_t filt);
    int acc;
    logic [7:0] p;
    logic [7:0] f;
    for (int r = 0; r < `CONV_OUT_ROWS; r++)
    begin
      for (int x = 0; x < `CONV_OUT_COLS; x++)
      begin
        acc = 0;
        for (int i = 0; i < `CONV_K; i++)
        begin
          for (int j = 0; j < `CONV_K; j++)
          begin
            p = img[((r + i) * `CONV_IMG_COLS + x + j) * 8 +: 8];
            f = filt[i][j];
            acc += int'(p) * int'(f);
          end
        end
        exp_tab[r][x] = conv_geom_pkg::osum_t'(acc);
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  // Called once the run has drained
  task automatic check_run();
    if (n_strobes != N_STROBES)
      flag_error($sformatf("got %0d result strobes instead of %0d", n_strobes, N_STROBES));
    if (n_done != 1)
      flag_error($sformatf("done pulsed %0d times instead of once", n_done));
    run_active = 1'b0;
  endtask

  task automatic end_test();
    if (test_errs == 0)
    begin
      $display("test %0s: ok", test_name);
      pass_tests++;
    end
    else
    begin
      $display("test %0s: %0d errors", test_name, test_errs);
      fail_tests++;
    end
  endtask

  task automatic check_strobe();
    int eg;
    int ec;
    int er;
    eg = n_strobes / `CONV_OUT_COLS;
    ec = n_strobes % `CONV_OUT_COLS;
    er = eg * `CONV_K;
    if (!run_active || n_strobes >= N_STROBES)
    begin
      flag_error("result strobe outside a run");
    end
    else
    begin
      if (cyc != start_edge + `CONV_LATENCY + 1 + n_strobes)
        flag_error($sformatf("strobe %0d came at cycle %0d, expected cycle %0d",
                   n_strobes, cyc, start_edge + `CONV_LATENCY + 1 + n_strobes));
      compare_value("o_grp", er, ec, eg, o_grp);
      compare_value("o_col", er, ec, ec, o_col);
      compare_value("o_sum0", er, ec, exp_tab[er][ec], o_sum0);
      compare_value("o_sum1", er + 1, ec, exp_tab[er+1][ec], o_sum1);
      compare_value("o_sum2", er + 2, ec, exp_tab[er+2][ec], o_sum2);
      compare_value("o_done", er, ec, (n_strobes == N_STROBES - 1), o_done);
    end
    if (o_done)
      n_done++;
    n_strobes++;
  endtask

  //////////////////////////////
  // Sampling away from the clock edge
  //////////////////////////////

  always @(negedge clk)
  begin
    if (!rst_n)
      fresh = 1'b1;
    if (fresh && (o_busy || o_valid || o_done || o_sum0 != 0 || o_sum1 != 0 || o_sum2 != 0))
      flag_error("outputs not idle during or right after reset");
    if (rst_n && done_prev && o_busy)
      flag_error("busy still high after the done pulse");
    done_prev = o_done;
    if (rst_n && o_done && !o_valid)
      flag_error("done pulsed without a result strobe");
    // Start is taken at the next edge
    if (rst_n && i_start && !o_busy)
    begin
      fresh      = 1'b0;
      run_active = 1'b1;
      start_edge = cyc + 1;
      n_strobes  = 0;
      n_done     = 0;
    end
    if (rst_n && o_valid)
      check_strobe();
  end

endmodule

//--- verif/tb_conv_top.sv
`timescale 1ns/100ps
`include "conv_params.svh"

module tb_conv_top;

  localparam int IMG_BITS = `CONV_IMG_ROWS * `CONV_IMG_COLS * 8;

  logic                     clk;
  logic                     rst_n;
  logic                     i_pix_we;
  conv_ctrl_pkg::row_idx_t  i_pix_row;
  conv_ctrl_pkg::col_idx_t  i_pix_col;
  conv_geom_pkg::pixel_t    i_pix_data;
  logic                     i_start;
  conv_geom_pkg::filter_t   i_filter;
  logic                     o_busy;
  logic                     o_valid;
  conv_ctrl_pkg::grp_idx_t  o_grp;
  conv_ctrl_pkg::col_idx_t  o_col;
  conv_geom_pkg::osum_t     o_sum0;
  conv_geom_pkg::osum_t     o_sum1;
  conv_geom_pkg::osum_t     o_sum2;
  logic                     o_done;

  conv_geom_pkg::filter_t   case_filt [2];
  logic [IMG_BITS-1:0]      case_img  [2];
  conv_geom_pkg::osum_t     case_exp  [2][`CONV_OUT_ROWS][`CONV_OUT_COLS];
  logic [31:0]              lfsr;
  logic                     aborted;

  conv_row_stationary_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_pix_we   (i_pix_we),
    .i_pix_row  (i_pix_row),
    .i_pix_col  (i_pix_col),
    .i_pix_data (i_pix_data),
    .i_start    (i_start),
    .i_filter   (i_filter),
    .o_busy     (o_busy),
    .o_valid    (o_valid),
    .o_grp      (o_grp),
    .o_col      (o_col),
    .o_sum0     (o_sum0),
    .o_sum1     (o_sum1),
    .o_sum2     (o_sum2),
    .o_done     (o_done)
  );

  conv_checker chk0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_start (i_start),
    .o_busy  (o_busy),
    .o_valid (o_valid),
    .o_grp   (o_grp),
    .o_col   (o_col),
    .o_sum0  (o_sum0),
    .o_sum1  (o_sum1),
    .o_sum2  (o_sum2),
    .o_done  (o_done)
  );

  initial
    clk = 1'b0;

  always #10 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic read_value(input int fd, output logic [31:0] v);
    if ($fscanf(fd, "%h", v) != 1)
    begin
      $display("stimulus file ended early or holds a bad value");
      aborted = 1'b1;
      v       = '0;
    end
  endtask

  task automatic read_stim();
    int fd;
    string line;
    logic [31:0] v;
    fd = $fopen("verif/conv_stim.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open verif/conv_stim.txt");
      aborted = 1'b1;
    end
    else
    begin
      void'($fgets(line, fd));
      void'($fgets(line, fd));
      for (int k = 0; k < 2; k++)
      begin
        for (int i = 0; i < `CONV_K; i++)
          for (int j = 0; j < `CONV_K; j++)
          begin
            read_value(fd, v);
            case_filt[k][i][j] = v[7:0];
          end
        for (int r = 0; r < `CONV_IMG_ROWS; r++)
          for (int c = 0; c < `CONV_IMG_COLS; c++)
          begin
            read_value(fd, v);
            case_img[k][(r * `CONV_IMG_COLS + c) * 8 +: 8] = v[7:0];
          end
        for (int r = 0; r < `CONV_OUT_ROWS; r++)
          for (int c = 0; c < `CONV_OUT_COLS; c++)
          begin
            read_value(fd, v);
            case_exp[k][r][c] = conv_geom_pkg::osum_t'(v);
          end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_pixel(input int r, input int c, input logic [7:0] d);
    @(posedge clk);
    i_pix_we   <= 1'b1;
    i_pix_row  <= conv_ctrl_pkg::row_idx_t'(r);
    i_pix_col  <= conv_ctrl_pkg::col_idx_t'(c);
    i_pix_data <= d;
    @(posedge clk);
    i_pix_we   <= 1'b0;
  endtask

  task automatic load_image(input logic [IMG_BITS-1:0] img);
    for (int r = 0; r < `CONV_IMG_ROWS; r++)
      for (int c = 0; c < `CONV_IMG_COLS; c++)
        write_pixel(r, c, img[(r * `CONV_IMG_COLS + c) * 8 +: 8]);
  endtask

  task automatic pulse_start(input conv_geom_pkg::filter_t filt);
    @(posedge clk);
    i_start  <= 1'b1;
    i_filter <= filt;
    @(posedge clk);
    i_start  <= 1'b0;
  endtask

  task automatic expect_case(input int k);
    for (int r = 0; r < `CONV_OUT_ROWS; r++)
      for (int c = 0; c < `CONV_OUT_COLS; c++)
        chk0.set_expected(r, c, case_exp[k][r][c]);
  endtask

  task automatic wait_run_end();
    int n;
    n = 0;
    @(negedge clk);
    while (o_busy && n < 200)
    begin
      @(negedge clk);
      n++;
    end
    if (o_busy)
    begin
      $display("timeout: run did not finish within 200 cycles");
      chk0.flag_error("run timed out");
      aborted = 1'b1;
    end
    else
    begin
      chk0.check_run();
    end
  endtask

  task automatic run_file_case(input string name, input int k);
    chk0.begin_test(name);
    load_image(case_img[k]);
    expect_case(k);
    pulse_start(case_filt[k]);
    wait_run_end();
    chk0.end_test();
  endtask

  task automatic run_start_busy();
    chk0.begin_test("start_while_busy");
    load_image(case_img[0]);
    expect_case(0);
    pulse_start(case_filt[0]);
    repeat (3) @(posedge clk);
    pulse_start(case_filt[1]);
    wait_run_end();
    chk0.end_test();
  endtask

  task automatic run_write_busy();
    chk0.begin_test("write_while_busy");
    expect_case(0);
    pulse_start(case_filt[0]);
    write_pixel(0, 0, 8'haa);
    wait_run_end();
    // No rewrite, so a dropped write leaves case 1 intact
    if (!aborted)
    begin
      pulse_start(case_filt[0]);
      wait_run_end();
    end
    chk0.end_test();
  endtask

  task automatic run_random();
    logic [IMG_BITS-1:0] img;
    conv_geom_pkg::filter_t filt;
    logic [7:0] b;
    chk0.begin_test("random");
    for (int i = 0; i < `CONV_IMG_ROWS * `CONV_IMG_COLS; i++)
    begin
      rand_byte(b);
      img[i*8 +: 8] = b;
    end
    for (int i = 0; i < `CONV_K; i++)
      for (int j = 0; j < `CONV_K; j++)
      begin
        rand_byte(b);
        filt[i][j] = b;
      end
    load_image(img);
    chk0.compute_expected(img, filt);
    pulse_start(filt);
    wait_run_end();
    chk0.end_test();
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    rst_n      = 1'b0;
    i_pix_we   = 1'b0;
    i_pix_row  = '0;
    i_pix_col  = '0;
    i_pix_data = '0;
    i_start    = 1'b0;
    i_filter   = '0;
    lfsr       = 32'h1b73;
    aborted    = 1'b0;
    read_stim();

    chk0.begin_test("reset");
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    chk0.end_test();

    if (!aborted)
      run_file_case("file_case_1", 0);
    if (!aborted)
      run_file_case("file_case_2", 1);
    if (!aborted)
      run_start_busy();
    if (!aborted)
      run_write_busy();
    if (!aborted)
      run_random();

    repeat (2) @(posedge clk);
    $display("tests passed: %0d, failed: %0d", chk0.pass_tests, chk0.fail_tests);
    if (aborted || chk0.fail_tests != 0 || chk0.test_errs != 0)
      $display("TESTBENCH FAILED");
    else
      $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verilog
verilog/conv_geom_pkg.sv
verilog/conv_ctrl_pkg.sv
verilog/image_row_buffer.sv
verilog/window_sequencer.sv
verilog/conv_pe.sv
verilog/pe_array.sv
verilog/conv_row_stationary_top.sv
verif/conv_checker.sv
verif/tb_conv_top.sv

//--- Makefile
# Verilator build and run of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_conv_top
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG BUILD_DIR FILELIST VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard verilog/*) $(wildcard verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/conv_stim.txt
# Per case: 3 filter rows of 3 taps, 8 image rows of 8 pixels, 6 expected rows of 6 sums
# All values hex; case 1 ramp image with mixed filter, case 2 all 255
01 02 01
00 01 00
02 00 01
00 01 02 03 04 05 06 07
08 09 0a 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17
18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27
28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37
38 39 3a 3b 3c 3d 3e 3f
3f 47 4f 57 5f 67
7f 87 8f 97 9f a7
bf c7 cf d7 df e7
ff 107 10f 117 11f 127
13f 147 14f 157 15f 167
17f 187 18f 197 19f 1a7

ff ff ff
ff ff ff
ff ff ff
ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff
ff ff ff ff ff ff ff ff
8ee09 8ee09 8ee09 8ee09 8ee09 8ee09
8ee09 8ee09 8ee09 8ee09 8ee09 8ee09
8ee09 8ee09 8ee09 8ee09 8ee09 8ee09
8ee09 8ee09 8ee09 8ee09 8ee09 8ee09
8ee09 8ee09 8ee09 8ee09 8ee09 8ee09
8ee09 8ee09 8ee09 8ee09 8ee09 8ee09
